//--- bp_addr_pkg.sv
package bp_addr_pkg;

    localparam int unsigned PC_W        = 32;   // fetch and execute pc width
    localparam int unsigned BTB_IDX_W   = 4;    // index bits shared by btb and bht
    localparam int unsigned BTB_ENTRIES = 16;   // 2**BTB_IDX_W rows
    localparam int unsigned IDX_LSB     = 2;    // pcs are word aligned, skip [1:0]
    localparam int unsigned TAG_W       = 26;   // everything above the index
    localparam int unsigned INSN_BYTES  = 4;    // fall-through step of a 32-bit insn

    // table row selected by a pc, bits [5:2]
    function automatic logic [BTB_IDX_W-1:0] pc_idx(input logic [PC_W-1:0] pc);
        return pc[IDX_LSB +: BTB_IDX_W];
    endfunction

    // btb tag of a pc, bits [31:6]
    function automatic logic [TAG_W-1:0] pc_tag(input logic [PC_W-1:0] pc);
        return pc[PC_W-1 -: TAG_W];
    endfunction

    // low bits that must be zero on an aligned pc
    function automatic logic pc_aligned(input logic [PC_W-1:0] pc);
        return pc[IDX_LSB-1:0] == '0;
    endfunction

endpackage

//--- bp_counter_pkg.sv
package bp_counter_pkg;

    localparam int unsigned HIST_W      = 4;    // outcomes kept per branch
    localparam int unsigned PHT_ENTRIES = 16;   // one counter per history pattern

    // 2-bit saturating counter, msb is the direction
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } ctr_state_e;

    localparam ctr_state_e CTR_RESET = weak_not_taken; // one taken flips it

    // taken decision of a counter state
    function automatic logic ctr_taken(input ctr_state_e state);
        return (state == weak_taken) || (state == strong_taken);
    endfunction

endpackage

//--- branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [bp_addr_pkg::PC_W-1:0] predict_pc,   // fetch pc from IF
    input  logic [bp_addr_pkg::PC_W-1:0] update_pc,    // resolved pc from EX
    input  logic                         valid,        // branch, jal or jalr resolved in EX
    input  logic                         branch_taken, // resolved direction
    input  logic [bp_addr_pkg::PC_W-1:0] target_pc,    // resolved target
    output logic [bp_addr_pkg::PC_W-1:0] predicted_pc  // next fetch address, same cycle
);

    import bp_addr_pkg::*;

    logic [PC_W-1:0] btb_target;   // stored target for the fetch row
    logic            btb_hit;      // target is known for this pc
    logic            dir_taken;    // direction predictor says taken
    logic [PC_W-1:0] fall_through; // sequential next pc

    btb branch_target_buffer (.clk, .rst_n,
        .predict_pc   (predict_pc),
        .update_pc    (update_pc),
        .valid        (valid),
        .target_pc    (target_pc),
        .predicted_pc (btb_target),
        .hit          (btb_hit)
    );

    local_branch_predictor direction_predictor (.clk, .rst_n,
        .predict_branch_pc   (predict_pc),
        .update_branch_pc    (update_pc),
        .valid               (valid),
        .actual_branch_taken (branch_taken),
        .prediction          (dir_taken)
    );

    assign fall_through = predict_pc + PC_W'(INSN_BYTES);

    // redirect only with both a known target and a taken guess
    assign predicted_pc = (btb_hit && dir_taken) ? btb_target : fall_through;

endmodule

//--- btb.sv
`timescale 1ns/1ps

module btb (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [bp_addr_pkg::PC_W-1:0] predict_pc,   // fetch pc from IF
    input  logic [bp_addr_pkg::PC_W-1:0] update_pc,    // resolved pc from EX
    input  logic                         valid,        // EX reports branch, jal or jalr
    input  logic [bp_addr_pkg::PC_W-1:0] target_pc,    // resolved target from EX
    output logic [bp_addr_pkg::PC_W-1:0] predicted_pc, // stored target of the fetch row
    output logic                         hit           // row valid and tag matches
);

    import bp_addr_pkg::*;

    logic [BTB_ENTRIES-1:0] entry_valid_q;             // per-row valid bits
    logic [TAG_W-1:0]       tag_q    [BTB_ENTRIES];    // pc[31:6] of the owner
    logic [PC_W-1:0]        target_q [BTB_ENTRIES];    // last resolved target

    logic [BTB_IDX_W-1:0]   pred_idx;                  // fetch side row
    logic [TAG_W-1:0]       pred_tag;
    logic [BTB_IDX_W-1:0]   upd_idx;                   // execute side row
    logic [TAG_W-1:0]       upd_tag;

    // split both pcs into row and tag
    always_comb begin
        pred_idx = pc_idx(predict_pc);
        pred_tag = pc_tag(predict_pc);
        upd_idx  = pc_idx(update_pc);
        upd_tag  = pc_tag(update_pc);
    end

    // lookup reads the registered rows, so a same-cycle write is not seen
    always_comb begin
        hit          = entry_valid_q[pred_idx] && (tag_q[pred_idx] == pred_tag);
        predicted_pc = target_q[pred_idx];             // only meaningful on hit
    end

    // row valid bits, set by every report
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid_q <= '0;
        end else if (valid) begin
            entry_valid_q[upd_idx] <= 1'b1;            // set whatever the outcome
        end
    end

    // tag and target payload, overwritten on every report
    always_ff @(posedge clk) begin
        if (valid) begin
            tag_q[upd_idx]    <= upd_tag;              // a new owner evicts the old one
            target_q[upd_idx] <= target_pc;
        end
    end

    // EX only reports aligned instruction addresses
    a_update_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |-> pc_aligned(update_pc)
    ) else $error("btb: unaligned update_pc %h", update_pc);

    // reset must leave no row able to produce an unknown hit
    a_hit_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(hit)
    ) else $error("btb: hit unknown for predict_pc %h", predict_pc);

endmodule

//--- compile.f
+incdir+.
bp_addr_pkg.sv
bp_counter_pkg.sv
btb.sv
local_history_table.sv
pattern_history_table.sv
local_branch_predictor.sv
branch_predictor.sv
tb_branch_predictor.sv

//--- local_branch_predictor.sv
`timescale 1ns/1ps

module local_branch_predictor (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [bp_addr_pkg::PC_W-1:0] predict_branch_pc,   // fetch pc from IF
    input  logic [bp_addr_pkg::PC_W-1:0] update_branch_pc,    // resolved pc from EX
    input  logic                         valid,               // EX report strobe
    input  logic                         actual_branch_taken, // resolved outcome
    output logic                         prediction           // taken for the fetch pc
);

    import bp_counter_pkg::*;

    logic [HIST_W-1:0] predict_history; // bht read for fetch, pht read index
    logic [HIST_W-1:0] update_history;  // bht read for EX, pht write index

    // first level, per-branch outcome shift registers
    local_history_table history_table (.clk, .rst_n,
        .predict_pc      (predict_branch_pc),
        .update_pc       (update_branch_pc),
        .valid           (valid),
        .branch_taken    (actual_branch_taken),
        .predict_history (predict_history),
        .update_history  (update_history)
    );

    // second level, counters selected by the history pattern
    pattern_history_table pattern_table (.clk, .rst_n,
        .predict_history (predict_history),
        .update_history  (update_history),
        .valid           (valid),
        .branch_taken    (actual_branch_taken),
        .prediction      (prediction)
    );

    // a history coming out of the bht must be a known pht index
    a_hist_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(predict_history) && !$isunknown(update_history)
    ) else $error("lbp: history unknown, pred %h upd %h",
                  predict_history, update_history);

endmodule

//--- local_history_table.sv
`timescale 1ns/1ps

module local_history_table (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [bp_addr_pkg::PC_W-1:0]     predict_pc,      // fetch pc
    input  logic [bp_addr_pkg::PC_W-1:0]     update_pc,       // resolved pc
    input  logic                             valid,           // shift strobe
    input  logic                             branch_taken,    // resolved outcome
    output logic [bp_counter_pkg::HIST_W-1:0] predict_history, // history of the fetch pc
    output logic [bp_counter_pkg::HIST_W-1:0] update_history   // history before this update
);

    import bp_addr_pkg::*;
    import bp_counter_pkg::*;

    logic [HIST_W-1:0]    hist_q [BTB_ENTRIES]; // newest outcome sits in bit 0
    logic [BTB_IDX_W-1:0] pred_idx;
    logic [BTB_IDX_W-1:0] upd_idx;

    assign pred_idx = pc_idx(predict_pc);
    assign upd_idx  = pc_idx(update_pc);

    // two combinational read ports
    assign predict_history = hist_q[pred_idx];
    assign update_history  = hist_q[upd_idx]; // old value, used by the pht write

    // histories are untagged, aliasing pcs share a row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                hist_q[i] <= '0;                     // all not taken
            end
        end else if (valid) begin
            hist_q[upd_idx] <= {hist_q[upd_idx][HIST_W-2:0], branch_taken};
        end
    end

    // the fetch stage never issues a misaligned pc
    a_predict_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_aligned(predict_pc)
    ) else $error("bht: unaligned predict_pc %h", predict_pc);

endmodule

//--- pattern_history_table.sv
`timescale 1ns/1ps

module pattern_history_table (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [bp_counter_pkg::HIST_W-1:0] predict_history, // read index
    input  logic [bp_counter_pkg::HIST_W-1:0] update_history,  // write index
    input  logic                              valid,           // train strobe
    input  logic                              branch_taken,    // resolved outcome
    output logic                              prediction       // taken for the fetch pc
);

    import bp_counter_pkg::*;

    ctr_state_e ctr_q [PHT_ENTRIES]; // one counter per history pattern
    ctr_state_e upd_ctr;             // counter being trained
    ctr_state_e ctr_next;            // its saturated next state

    // read port, sees the state before any write this cycle
    assign prediction = ctr_taken(ctr_q[predict_history]);

    assign upd_ctr = ctr_q[update_history];

    // one step toward the outcome, held at both ends
    always_comb begin
        case (upd_ctr)
            strong_not_taken: ctr_next = branch_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   ctr_next = branch_taken ? weak_taken     : strong_not_taken;
            weak_taken:       ctr_next = branch_taken ? strong_taken   : weak_not_taken;
            strong_taken:     ctr_next = branch_taken ? strong_taken   : weak_taken;
            default:          ctr_next = CTR_RESET; // unreachable for a 2-bit enum
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (valid) begin
            ctr_q[update_history] <= ctr_next;
        end
    end

    // every counter keeps a legal state once reset has run
    for (genvar g = 0; g < PHT_ENTRIES; g++) begin : g_ctr_chk
        a_ctr_legal : assert property (
            @(posedge clk) disable iff (!rst_n)
            ctr_q[g] inside {strong_not_taken, weak_not_taken, weak_taken, strong_taken}
        ) else $error("pht: counter %0d left its range", g);
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build with verilator from compile.f, run, then search the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_branch_predictor \
    -Mdir obj_dir -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -q "^Testbench passed$" sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL, see sim.log"; exit 1; }

//--- tb_bp_model.svh
`ifndef TB_BP_MODEL_SVH
`define TB_BP_MODEL_SVH

// reference copies of the btb, the bht and the pht
logic              m_btb_valid  [BTB_ENTRIES];
logic [TAG_W-1:0]  m_btb_tag    [BTB_ENTRIES];
logic [PC_W-1:0]   m_btb_target [BTB_ENTRIES];
logic [HIST_W-1:0] m_hist       [BTB_ENTRIES];
ctr_state_e        m_ctr        [PHT_ENTRIES];

// state right after a reset edge
function automatic void model_reset();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_btb_valid[i]  = 1'b0;
        m_btb_tag[i]    = '0;
        m_btb_target[i] = '0;
        m_hist[i]       = '0;                       // no outcomes seen yet
    end
    for (int i = 0; i < PHT_ENTRIES; i++) begin
        m_ctr[i] = weak_not_taken;
    end
endfunction

// next fetch address for pc, before any update of this cycle
function automatic logic [PC_W-1:0] model_predict(input logic [PC_W-1:0] pc);
    logic [3:0] row;
    logic       hit;
    logic       taken;
    row   = pc[5:2];                                // word aligned, 16 rows
    hit   = m_btb_valid[row] && (m_btb_tag[row] == pc[31:6]);
    taken = (m_ctr[m_hist[row]] >= weak_taken);     // upper half of the counter range
    if (hit && taken) begin
        return m_btb_target[row];
    end else begin
        return pc + 32'd4;
    end
endfunction

// one resolved report from execute
function automatic void model_update(input logic [PC_W-1:0] pc, input logic taken,
                                     input logic [PC_W-1:0] target);
    logic [3:0] row;
    logic [3:0] old_hist;
    row      = pc[5:2];
    old_hist = m_hist[row];                         // pht is trained with the old history
    if (taken && m_ctr[old_hist] != strong_taken) begin
        m_ctr[old_hist] = ctr_state_e'(m_ctr[old_hist] + 2'd1);
    end else if (!taken && m_ctr[old_hist] != strong_not_taken) begin
        m_ctr[old_hist] = ctr_state_e'(m_ctr[old_hist] - 2'd1);
    end
    m_hist[row]       = {old_hist[2:0], taken};     // newest outcome in bit 0
    m_btb_valid[row]  = 1'b1;                       // written whatever the outcome
    m_btb_tag[row]    = pc[31:6];
    m_btb_target[row] = target;
endfunction

`endif

//--- tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

    import bp_addr_pkg::*;
    import bp_counter_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int RESET_TIMEOUT = 50;              // cycles allowed for a known output
    localparam int NUM_CYCLES    = 3000;
    localparam int WATCHDOG_NS   = (NUM_CYCLES + 200) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'd74779;
    localparam int POOL_SIZE     = 12;
    localparam int ALT_SLOT      = 11;              // alternates taken / not taken
    localparam int JALR_SLOT     = 10;              // target changes on every report

    // slots 0/1, 3/4 and 8/9 share a row but differ in tag
    localparam logic [31:0] POOL_PC [POOL_SIZE] = '{
        32'h0000_1000, 32'h0000_2000, 32'h0000_1004, 32'h0000_1008,
        32'h0000_3008, 32'h0000_100C, 32'h0000_1010, 32'h0000_1014,
        32'h0000_1018, 32'h0000_4018, 32'h0000_101C, 32'h0000_1020
    };
    localparam logic [31:0] POOL_TARGET [POOL_SIZE] = '{
        32'h0000_8000, 32'h0000_8040, 32'h0000_8080, 32'h0000_80C0,
        32'h0000_8100, 32'h0000_8140, 32'h0000_8180, 32'h0000_81C0,
        32'h0000_8200, 32'h0000_8240, 32'h0000_8280, 32'h0000_82C0
    };
    localparam int TAKEN_PCT [POOL_SIZE] = '{95, 20, 90, 85, 10, 70, 100, 5, 80, 60, 50, 0};

    logic            clk;
    logic            rst_n;
    logic [PC_W-1:0] predict_pc;
    logic [PC_W-1:0] update_pc;
    logic            valid;
    logic            branch_taken;
    logic [PC_W-1:0] target_pc;
    logic [PC_W-1:0] predicted_pc;

    logic [31:0] lcg_state;
    logic        alt_next;                          // next outcome of the alternating slot
    int          checks;
    int          errors;
    int          timeouts;
    int          redirects;                         // checks that expected a btb target
    int          collisions;                        // same row predicted and updated

    `include "tb_bp_model.svh"

    branch_predictor i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .predict_pc   (predict_pc),
        .update_pc    (update_pc),
        .valid        (valid),
        .branch_taken (branch_taken),
        .target_pc    (target_pc),
        .predicted_pc (predicted_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit in case a wait never returns
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int percent_roll();
        return int'((lcg_next() >> 8) % 32'd100); // upper bits, low ones cycle fast
    endfunction

    function automatic int pool_slot();
        return int'((lcg_next() >> 8) % 32'd12);
    endfunction

    // keep rst_n low for the reset cycles and until predicted_pc is known
    task automatic hold_reset();
        int cycles;
        cycles = 0;
        while ((cycles < RESET_CYCLES || $isunknown(predicted_pc)) && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= RESET_TIMEOUT) begin
            timeouts++;
            $display("timeout: predicted_pc still unknown after %0d reset cycles", cycles);
        end
    endtask

    task automatic compare_pc(input logic [PC_W-1:0] expected);
        checks++;
        if (predicted_pc !== expected) begin
            errors++;
            $display("[ERROR] %0t ns predicted_pc expected %h actual %h",
                     $time, expected, predicted_pc);
        end
    endtask

    task automatic drive_random();
        int          p;
        int          u;
        logic [31:0] rnd;
        p = pool_slot();
        u = (percent_roll() < 25) ? p : pool_slot(); // force some same-row cycles
        predict_pc = POOL_PC[p];
        update_pc  = POOL_PC[u];
        valid      = (percent_roll() < 60);
        if (u == ALT_SLOT) begin
            branch_taken = alt_next;
            if (valid) alt_next = !alt_next;         // flips only when reported
        end else begin
            branch_taken = (percent_roll() < TAKEN_PCT[u]);
        end
        if (u == JALR_SLOT) begin
            rnd       = lcg_next();
            target_pc = {16'h0000, rnd[15:2], 2'b00};
        end else begin
            target_pc = POOL_TARGET[u];
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        predict_pc   = POOL_PC[0];
        update_pc    = POOL_PC[0];
        valid        = 1'b0;
        branch_taken = 1'b0;
        target_pc    = '0;
        lcg_state    = SEED;
        alt_next     = 1'b1;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        redirects    = 0;
        collisions   = 0;
        model_reset();

        hold_reset();
        rst_n = 1'b1;                                // released on a falling edge

        // empty tables, every pool pc falls through
        for (int i = 0; i < POOL_SIZE; i++) begin
            @(negedge clk);
            predict_pc = POOL_PC[i];
            valid      = 1'b0;
            #(CLK_PERIOD / 4);
            compare_pc(POOL_PC[i] + 32'd4);
        end

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk);
            drive_random();
            #(CLK_PERIOD / 4);                       // mid low phase, lookup has settled
            if (model_predict(predict_pc) != predict_pc + 32'd4) redirects++;
            if (valid && predict_pc[5:2] == update_pc[5:2]) collisions++;
            compare_pc(model_predict(predict_pc)); // old state, the edge has not come yet
            if (valid) model_update(update_pc, branch_taken, target_pc);
        end

        if (redirects == 0) begin
            errors++;
            $display("no cycle expected a btb target, training never reached a taken state");
        end
        if (collisions == 0) begin
            errors++;
            $display("no cycle predicted and updated the same row");
        end

        $display("checks %0d, value errors %0d, timeouts %0d, redirects %0d, collisions %0d",
                 checks, errors, timeouts, redirects, collisions);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
